// File: Makefile
TOP = mipsCore_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f all.f --top-module $(TOP)

obj_dir/simv: all.f design/mips_params.svh $(wildcard design/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps -f all.f \
		--top-module $(TOP) -o simv

sim: obj_dir/simv
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: all.f
+incdir+design
design/mipsPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsCore.sv
dv/mipsCore_assert.sv
dv/mipsCore_tb.sv

// File: design/decodeStage.sv
/* Instruction decode stage */

`include "mips_params.svh"

module decodeStage (
	input  logic clk,
	input  logic reset,
	input  logic squash,
	input  logic [`DATA_WIDTH-1:0] instr,
	input  logic [`DATA_WIDTH-1:0] pcPlus4,
	input  logic wbEnable,
	input  logic [`REG_ADDR_WIDTH-1:0] wbRegister,
	input  logic [`DATA_WIDTH-1:0] wbData,
	output logic [`DATA_WIDTH-1:0] exPcPlus4,
	output logic [`DATA_WIDTH-1:0] exReadData1,
	output logic [`DATA_WIDTH-1:0] exReadData2,
	output logic [`DATA_WIDTH-1:0] exImmExtend,
	output logic [25:0] exJumpIndex,
	output logic [`REG_ADDR_WIDTH-1:0] exDestReg,
	output mipsPkg::aluOpT exAluOp,
	output logic exAluSrc,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exBranchEq,
	output logic exBranchNe,
	output logic exJump
);

	import mipsPkg::*;

	localparam int regCount = 2 ** `REG_ADDR_WIDTH;

	// R-format function codes
	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr  = 6'h25;
	localparam logic [5:0] functNor = 6'h27;

	instrWord decInstr;
	aluOpT aluOp;
	logic regDst;
	logic zeroExt;
	logic aluSrc;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic branchEq;
	logic branchNe;
	logic jump;
	logic [`REG_ADDR_WIDTH-1:0] destReg;
	logic [`DATA_WIDTH-1:0] readData1;
	logic [`DATA_WIDTH-1:0] readData2;
	logic [`DATA_WIDTH-1:0] immExtend;
	logic [`DATA_WIDTH-1:0] regFile [regCount];

	assign decInstr = instr;

	// Main control
	always_comb begin
		aluOp = aluPass;
		regDst = 1'b0;
		zeroExt = 1'b0;
		aluSrc = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		case (decInstr.i.opcode)
			opRType: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				case (decInstr.r.funct)
					functAdd: aluOp = aluAdd;
					functSub: aluOp = aluSub;
					functAnd: aluOp = aluAnd;
					functOr:  aluOp = aluOr;
					functNor: aluOp = aluNor;
					// Unsupported funct and the nop word
					default:  regWrite = 1'b0;
				endcase
			end
			opAddi: begin
				aluOp = aluAdd;
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			opOri: begin
				aluOp = aluOr;
				aluSrc = 1'b1;
				zeroExt = 1'b1;
				regWrite = 1'b1;
			end
			opLw: begin
				aluOp = aluAdd;
				aluSrc = 1'b1;
				regWrite = 1'b1;
				memRead = 1'b1;
			end
			opSw: begin
				aluOp = aluAdd;
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			// Compare by subtraction
			opBeq: begin
				aluOp = aluSub;
				branchEq = 1'b1;
			end
			opBne: begin
				aluOp = aluSub;
				branchNe = 1'b1;
			end
			opJ:     jump = 1'b1;
			default: aluOp = aluPass;
		endcase
	end

	// rd for R-format, rt otherwise
	assign destReg = regDst ? decInstr.r.rd : decInstr.i.rt;

	// ori takes a zero extended immediate
	assign immExtend = zeroExt ? {16'b0, decInstr.i.imm}
		: {{16{decInstr.i.imm[15]}}, decInstr.i.imm};

	// Register file write port from writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++)
				regFile[i] <= '0;
		end else if (wbEnable && wbRegister != '0) begin
			regFile[wbRegister] <= wbData;
		end
	end

	// Read ports with same cycle write through
	// Register 0 always reads zero
	assign readData1 = (decInstr.i.rs == '0) ? '0
		: (wbEnable && wbRegister == decInstr.i.rs) ? wbData
		: regFile[decInstr.i.rs];
	assign readData2 = (decInstr.i.rt == '0) ? '0
		: (wbEnable && wbRegister == decInstr.i.rt) ? wbData
		: regFile[decInstr.i.rt];

	// ID/EX register
	always_ff @(posedge clk) begin
		if (reset || squash) begin
			exAluSrc <= 1'b0;
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exBranchEq <= 1'b0;
			exBranchNe <= 1'b0;
			exJump <= 1'b0;
		end else begin
			exAluSrc <= aluSrc;
			// Writes to register 0 dropped here
			exRegWrite <= regWrite && (destReg != '0);
			exMemRead <= memRead;
			exMemWrite <= memWrite;
			exBranchEq <= branchEq;
			exBranchNe <= branchNe;
			exJump <= jump;
		end
		exAluOp <= aluOp;
		exPcPlus4 <= pcPlus4;
		exReadData1 <= readData1;
		exReadData2 <= readData2;
		exImmExtend <= immExtend;
		exJumpIndex <= {decInstr.i.rs, decInstr.i.rt, decInstr.i.imm};
		exDestReg <= destReg;
	end

endmodule

// File: design/executeStage.sv
/* Execute stage */

`include "mips_params.svh"

module executeStage (
	input  logic clk,
	input  logic reset,
	input  logic squash,
	input  logic [`DATA_WIDTH-1:0] exPcPlus4,
	input  logic [`DATA_WIDTH-1:0] exReadData1,
	input  logic [`DATA_WIDTH-1:0] exReadData2,
	input  logic [`DATA_WIDTH-1:0] exImmExtend,
	input  logic [25:0] exJumpIndex,
	input  logic [`REG_ADDR_WIDTH-1:0] exDestReg,
	input  mipsPkg::aluOpT exAluOp,
	input  logic exAluSrc,
	input  logic exRegWrite,
	input  logic exMemRead,
	input  logic exMemWrite,
	input  logic exBranchEq,
	input  logic exBranchNe,
	input  logic exJump,
	output logic [`DATA_WIDTH-1:0] memAluResult,
	output logic memZero,
	output logic [`DATA_WIDTH-1:0] memStoreData,
	output logic [`DATA_WIDTH-1:0] memBranchTarget,
	output logic [`DATA_WIDTH-1:0] memJumpTarget,
	output logic [`REG_ADDR_WIDTH-1:0] memDestReg,
	output logic memRegWrite,
	output logic memMemRead,
	output logic memMemWrite,
	output logic memBranchEq,
	output logic memBranchNe,
	output logic memJump
);

	import mipsPkg::*;

	logic [`DATA_WIDTH-1:0] operandB;
	logic [`DATA_WIDTH-1:0] aluResult;

	// Second operand from register or immediate
	assign operandB = exAluSrc ? exImmExtend : exReadData2;

	always_comb begin
		case (exAluOp)
			aluAdd:  aluResult = exReadData1 + operandB;
			aluSub:  aluResult = exReadData1 - operandB;
			aluAnd:  aluResult = exReadData1 & operandB;
			aluOr:   aluResult = exReadData1 | operandB;
			aluNor:  aluResult = ~(exReadData1 | operandB);
			aluPass: aluResult = operandB;
			default: aluResult = '0;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (reset || squash) begin
			memRegWrite <= 1'b0;
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
			memBranchEq <= 1'b0;
			memBranchNe <= 1'b0;
			memJump <= 1'b0;
		end else begin
			memRegWrite <= exRegWrite;
			memMemRead <= exMemRead;
			memMemWrite <= exMemWrite;
			memBranchEq <= exBranchEq;
			memBranchNe <= exBranchNe;
			memJump <= exJump;
		end
		memAluResult <= aluResult;
		memZero <= (aluResult == '0);
		memStoreData <= exReadData2;
		// Word offset relative to the delay slot address
		memBranchTarget <= exPcPlus4 + {exImmExtend[`DATA_WIDTH-3:0], 2'b00};
		// Region bits kept from PC+4
		memJumpTarget <= {exPcPlus4[31:28], exJumpIndex, 2'b00};
		memDestReg <= exDestReg;
	end

endmodule

// File: design/fetchStage.sv
/* Instruction fetch stage */

`include "mips_params.svh"

module fetchStage (
	input  logic clk,
	input  logic reset,
	input  logic redirect,
	input  logic [`DATA_WIDTH-1:0] redirectPc,
	input  logic progWrite,
	input  logic [`IMEM_ADDR_WIDTH-1:0] progAddr,
	input  logic [`DATA_WIDTH-1:0] progData,
	output logic [`DATA_WIDTH-1:0] instr,
	output logic [`DATA_WIDTH-1:0] pcPlus4
);

	logic [`DATA_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] nextPc;
	logic [`DATA_WIDTH-1:0] imem [`IMEM_DEPTH];

	// Program load only while held in reset
	always_ff @(posedge clk) begin
		if (reset && progWrite)
			imem[progAddr] <= progData;
	end

	assign nextPc = pc + `DATA_WIDTH'd4;

	// Redirect from memory stage wins over sequential fetch
	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (redirect)
			pc <= redirectPc;
		else
			pc <= nextPc;
	end

	// IF/ID register
	// Zero word is a nop and marks the squashed slot
	always_ff @(posedge clk) begin
		if (reset || redirect)
			instr <= '0;
		else
			instr <= imem[pc[`IMEM_ADDR_WIDTH+1:2]];
		pcPlus4 <= nextPc;
	end

endmodule

// File: design/memoryStage.sv
/* Memory access stage */

`include "mips_params.svh"

module memoryStage (
	input  logic clk,
	input  logic reset,
	input  logic [`DATA_WIDTH-1:0] memAluResult,
	input  logic memZero,
	input  logic [`DATA_WIDTH-1:0] memStoreData,
	input  logic [`DATA_WIDTH-1:0] memBranchTarget,
	input  logic [`DATA_WIDTH-1:0] memJumpTarget,
	input  logic [`REG_ADDR_WIDTH-1:0] memDestReg,
	input  logic memRegWrite,
	input  logic memMemRead,
	input  logic memMemWrite,
	input  logic memBranchEq,
	input  logic memBranchNe,
	input  logic memJump,
	output logic redirect,
	output logic [`DATA_WIDTH-1:0] redirectPc,
	output logic wbEnable,
	output logic [`REG_ADDR_WIDTH-1:0] wbRegister,
	output logic [`DATA_WIDTH-1:0] wbData
);

	localparam int dmemAddrWidth = $clog2(`DMEM_DEPTH);

	logic [dmemAddrWidth-1:0] wordAddr;
	logic [`DATA_WIDTH-1:0] readData;
	logic branchTaken;
	logic [`DATA_WIDTH-1:0] dmem [`DMEM_DEPTH];

	// Byte offset bits dropped
	assign wordAddr = memAluResult[dmemAddrWidth+1:2];
	assign readData = dmem[wordAddr];

	// Never stored words read zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DMEM_DEPTH; i++)
				dmem[i] <= '0;
		end else if (memMemWrite) begin
			dmem[wordAddr] <= memStoreData;
		end
	end

	// Branch resolution from the subtract result
	assign branchTaken = (memBranchEq && memZero) || (memBranchNe && !memZero);
	assign redirect = branchTaken || memJump;
	assign redirectPc = memJump ? memJumpTarget : memBranchTarget;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (reset)
			wbEnable <= 1'b0;
		else
			wbEnable <= memRegWrite;
		wbRegister <= memDestReg;
		wbData <= memMemRead ? readData : memAluResult;
	end

endmodule

// File: design/mipsCore.sv
/* Pipelined MIPS core */

`include "mips_params.svh"

module mipsCore (
	input  logic clk,
	input  logic reset,
	input  logic progWrite,
	input  logic [`IMEM_ADDR_WIDTH-1:0] progAddr,
	input  logic [`DATA_WIDTH-1:0] progData,
	output logic [`DATA_WIDTH-1:0] aluResultOut,
	output logic wbEnable,
	output logic [`REG_ADDR_WIDTH-1:0] wbRegister,
	output logic [`DATA_WIDTH-1:0] wbData
);

	import mipsPkg::*;

	// Fetch to decode
	logic [`DATA_WIDTH-1:0] instr;
	logic [`DATA_WIDTH-1:0] pcPlus4;

	// Decode to execute
	logic [`DATA_WIDTH-1:0] exPcPlus4;
	logic [`DATA_WIDTH-1:0] exReadData1;
	logic [`DATA_WIDTH-1:0] exReadData2;
	logic [`DATA_WIDTH-1:0] exImmExtend;
	logic [25:0] exJumpIndex;
	logic [`REG_ADDR_WIDTH-1:0] exDestReg;
	aluOpT exAluOp;
	logic exAluSrc;
	logic exRegWrite;
	logic exMemRead;
	logic exMemWrite;
	logic exBranchEq;
	logic exBranchNe;
	logic exJump;

	// Execute to memory
	logic [`DATA_WIDTH-1:0] memAluResult;
	logic memZero;
	logic [`DATA_WIDTH-1:0] memStoreData;
	logic [`DATA_WIDTH-1:0] memBranchTarget;
	logic [`DATA_WIDTH-1:0] memJumpTarget;
	logic [`REG_ADDR_WIDTH-1:0] memDestReg;
	logic memRegWrite;
	logic memMemRead;
	logic memMemWrite;
	logic memBranchEq;
	logic memBranchNe;
	logic memJump;

	// Redirect back to fetch, also the squash for the younger three
	logic redirect;
	logic [`DATA_WIDTH-1:0] redirectPc;

	fetchStage ifStage (
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.instr(instr),
		.pcPlus4(pcPlus4)
	);

	decodeStage idStage (
		.clk(clk),
		.reset(reset),
		.squash(redirect),
		.instr(instr),
		.pcPlus4(pcPlus4),
		.wbEnable(wbEnable),
		.wbRegister(wbRegister),
		.wbData(wbData),
		.exPcPlus4(exPcPlus4),
		.exReadData1(exReadData1),
		.exReadData2(exReadData2),
		.exImmExtend(exImmExtend),
		.exJumpIndex(exJumpIndex),
		.exDestReg(exDestReg),
		.exAluOp(exAluOp),
		.exAluSrc(exAluSrc),
		.exRegWrite(exRegWrite),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exBranchEq(exBranchEq),
		.exBranchNe(exBranchNe),
		.exJump(exJump)
	);

	executeStage exStage (
		.clk(clk),
		.reset(reset),
		.squash(redirect),
		.exPcPlus4(exPcPlus4),
		.exReadData1(exReadData1),
		.exReadData2(exReadData2),
		.exImmExtend(exImmExtend),
		.exJumpIndex(exJumpIndex),
		.exDestReg(exDestReg),
		.exAluOp(exAluOp),
		.exAluSrc(exAluSrc),
		.exRegWrite(exRegWrite),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exBranchEq(exBranchEq),
		.exBranchNe(exBranchNe),
		.exJump(exJump),
		.memAluResult(memAluResult),
		.memZero(memZero),
		.memStoreData(memStoreData),
		.memBranchTarget(memBranchTarget),
		.memJumpTarget(memJumpTarget),
		.memDestReg(memDestReg),
		.memRegWrite(memRegWrite),
		.memMemRead(memMemRead),
		.memMemWrite(memMemWrite),
		.memBranchEq(memBranchEq),
		.memBranchNe(memBranchNe),
		.memJump(memJump)
	);

	memoryStage memStage (
		.clk(clk),
		.reset(reset),
		.memAluResult(memAluResult),
		.memZero(memZero),
		.memStoreData(memStoreData),
		.memBranchTarget(memBranchTarget),
		.memJumpTarget(memJumpTarget),
		.memDestReg(memDestReg),
		.memRegWrite(memRegWrite),
		.memMemRead(memMemRead),
		.memMemWrite(memMemWrite),
		.memBranchEq(memBranchEq),
		.memBranchNe(memBranchNe),
		.memJump(memJump),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.wbEnable(wbEnable),
		.wbRegister(wbRegister),
		.wbData(wbData)
	);

	// EX/MEM ALU result seen from outside
	assign aluResultOut = memAluResult;

endmodule

// File: design/mipsPkg.sv
/* MIPS core types */

`include "mips_params.svh"

package mipsPkg;

	// Opcodes of the supported subset
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opOri   = 6'h0D,
		opLw    = 6'h23,
		opSw    = 6'h2B
	} opcodeT;

	// ALU operations
	typedef enum logic [2:0] {
		aluAdd  = 3'd0,
		aluSub  = 3'd1,
		aluAnd  = 3'd2,
		aluOr   = 3'd3,
		aluNor  = 3'd4,
		aluPass = 3'd5
	} aluOpT;

	// Register format view
	typedef struct packed {
		opcodeT opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormatT;

	// Immediate format view
	// Jump index is the low 26 bits of this view
	typedef struct packed {
		opcodeT opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [15:0] imm;
	} iFormatT;

	// One instruction word, two decodings
	typedef union packed {
		rFormatT r;
		iFormatT i;
	} instrWord;

endpackage

// File: design/mips_params.svh
/* MIPS core sizes */

`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Machine word
`define DATA_WIDTH 32

// Instruction memory in words
`define IMEM_DEPTH 64

// Word address into instruction memory
`define IMEM_ADDR_WIDTH 6

// Data memory in words
`define DMEM_DEPTH 64

// Register index
// 32 architectural registers
`define REG_ADDR_WIDTH 5

`endif

// File: dv/mipsCore_assert.sv
/* Pipeline assertions */

`include "mips_params.svh"

module mipsCoreAssert (
	input logic clk,
	input logic reset,
	input logic redirect,
	input logic wbEnable,
	input logic [`REG_ADDR_WIDTH-1:0] wbRegister
);

	timeunit 1ns;
	timeprecision 100ps;

	// Register 0 writes never reach writeback
	noZeroWrite: assert property (@(posedge clk) disable iff (reset)
		wbEnable |-> wbRegister != '0)
		else $error("writeback enabled for register 0");

	// Cleared pipeline cannot redirect
	quietAfterReset: assert property (@(posedge clk)
		reset |=> !redirect)
		else $error("redirect high in the cycle after reset");

	// Writeback enable always driven
	wbKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(wbEnable))
		else $error("writeback enable unknown");

endmodule

bind mipsCore mipsCoreAssert pipeCheck (
	.clk(clk),
	.reset(reset),
	.redirect(redirect),
	.wbEnable(wbEnable),
	.wbRegister(wbRegister)
);

// File: dv/mipsCore_tb.sv
/* MIPS core testbench */

`include "mips_params.svh"

module mipsCore_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import mipsPkg::*;

	localparam int clkPeriod = 40;
	localparam int randCount = 48;
	// Random body plus the closing self jump
	localparam int progLen = randCount + 1;
	localparam int loadCycles = `IMEM_DEPTH + 2;
	// Worst case one redirect per instruction, three bubbles each
	localparam int timeoutNs = (loadCycles + (progLen + 5) * 4) * clkPeriod;
	localparam int dmemBits = $clog2(`DMEM_DEPTH);

	logic clk;
	logic reset;
	logic progWrite;
	logic [`IMEM_ADDR_WIDTH-1:0] progAddr;
	logic [`DATA_WIDTH-1:0] progData;
	logic [`DATA_WIDTH-1:0] aluResultOut;
	logic wbEnable;
	logic [`REG_ADDR_WIDTH-1:0] wbRegister;
	logic [`DATA_WIDTH-1:0] wbData;

	logic [15:0] lfsrState;
	logic [`DATA_WIDTH-1:0] progMem [`IMEM_DEPTH];
	int lastWrite [32];
	logic [`REG_ADDR_WIDTH-1:0] expReg [$];
	logic [`DATA_WIDTH-1:0] expData [$];
	logic [`DATA_WIDTH-1:0] expAlu [$];
	logic [`DATA_WIDTH-1:0] prevAlu;
	int expCount;
	int redirects;
	int errors;
	int checks;
	int wbSeen;
	int edgeCount;

	mipsCore DUT (
		.clk(clk),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.aluResultOut(aluResultOut),
		.wbEnable(wbEnable),
		.wbRegister(wbRegister),
		.wbData(wbData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Galois LFSR, one step per bit taken
	function automatic int randBits(int n);
		int value;
		value = 0;
		for (int k = 0; k < n; k++) begin
			value = (value << 1) | int'(lfsrState[0]);
			if (lfsrState[0])
				lfsrState = (lfsrState >> 1) ^ 16'hB400;
			else
				lfsrState = lfsrState >> 1;
		end
		return value;
	endfunction

	function automatic logic [5:0] functOf(int sel);
		case (sel)
			0: return 6'h20;
			1: return 6'h22;
			2: return 6'h24;
			3: return 6'h25;
			default: return 6'h27;
		endcase
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] encodeR(logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd, logic [5:0] funct);
		instrWord w;
		w.r.opcode = opRType;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = '0;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] encodeI(opcodeT op, logic [4:0] rs,
			logic [4:0] rt, logic [15:0] imm);
		instrWord w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	// Target word index sits in the low 26 bits
	function automatic logic [`DATA_WIDTH-1:0] encodeJ(int target);
		instrWord w;
		w.i.opcode = opJ;
		{w.i.rs, w.i.rt, w.i.imm} = 26'(target);
		return w;
	endfunction

	// Register readable only three slots after its last write
	function automatic logic [4:0] pickSource(int pos);
		logic [4:0] r;
		r = 5'(randBits(5));
		if (r != '0 && pos - lastWrite[r] < 3)
			r = '0;
		return r;
	endfunction

	// Forward past the shadow, never beyond the closing self jump
	function automatic int pickTarget(int pos);
		int t;
		t = pos + 4 + randBits(2);
		if (t > randCount)
			t = randCount;
		return t;
	endfunction

	task automatic buildProgram();
		int kind;
		int target;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		for (int r = 0; r < 32; r++)
			lastWrite[r] = -8;
		// Known first write for the latency check
		progMem[0] = encodeI(opOri, 5'd0, 5'd1, 16'(randBits(16)));
		lastWrite[1] = 0;
		for (int i = 1; i < randCount; i++) begin
			rs = pickSource(i);
			rt = pickSource(i);
			rd = 5'(randBits(5));
			kind = randBits(3);
			case (kind)
				0: progMem[i] = encodeR(rs, rt, rd, functOf(randBits(3) % 5));
				1: progMem[i] = encodeI(opAddi, rs, rd, 16'(randBits(16)));
				2: progMem[i] = encodeI(opOri, rs, rd, 16'(randBits(16)));
				// Small word offsets from register 0 so loads hit stores
				3: progMem[i] = encodeI(opLw, 5'd0, rd, 16'(randBits(3) * 4));
				4: progMem[i] = encodeI(opSw, 5'd0, rt, 16'(randBits(3) * 4));
				5, 6: begin
					// Equal operands half the time so branches do get taken
					if (randBits(1) == 1)
						rt = rs;
					target = pickTarget(i);
					progMem[i] = encodeI(kind == 5 ? opBeq : opBne, rs, rt,
						16'(target - i - 1));
				end
				default: progMem[i] = encodeJ(pickTarget(i));
			endcase
			if (kind <= 3)
				lastWrite[rd] = i;
		end
		progMem[randCount] = encodeJ(randCount);
		// Unused words each jump to themselves
		for (int a = progLen; a < `IMEM_DEPTH; a++)
			progMem[a] = encodeJ(a);
	endtask

	// In-order architectural model, no delay slot
	task automatic runModel();
		logic [`DATA_WIDTH-1:0] regs [32];
		logic [`DATA_WIDTH-1:0] mem [`DMEM_DEPTH];
		instrWord w;
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] b;
		logic [`DATA_WIDTH-1:0] signImm;
		logic [`DATA_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] result;
		logic [4:0] dest;
		logic writes;
		int pc;
		int steps;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		for (int m = 0; m < `DMEM_DEPTH; m++)
			mem[m] = '0;
		pc = 0;
		steps = 0;
		while (pc != randCount && steps < 4 * progLen) begin
			w = progMem[pc];
			a = regs[w.i.rs];
			b = regs[w.i.rt];
			signImm = {{16{w.i.imm[15]}}, w.i.imm};
			addr = a + signImm;
			dest = w.i.rt;
			writes = 1'b1;
			result = '0;
			pc = pc + 1;
			case (w.i.opcode)
				opRType: begin
					dest = w.r.rd;
					case (w.r.funct)
						6'h20: result = a + b;
						6'h22: result = a - b;
						6'h24: result = a & b;
						6'h25: result = a | b;
						6'h27: result = ~(a | b);
						default: writes = 1'b0;
					endcase
				end
				opAddi: result = a + signImm;
				opOri: result = a | {16'b0, w.i.imm};
				opLw: result = mem[addr[dmemBits+1:2]];
				opSw: begin
					writes = 1'b0;
					mem[addr[dmemBits+1:2]] = b;
				end
				opBeq, opBne: begin
					writes = 1'b0;
					if ((a == b) == (w.i.opcode == opBeq)) begin
						pc = pc + int'($signed(w.i.imm));
						redirects++;
					end
				end
				default: begin
					writes = 1'b0;
					pc = int'({w.i.rs, w.i.rt, w.i.imm});
					redirects++;
				end
			endcase
			if (writes && dest != '0) begin
				regs[dest] = result;
				expReg.push_back(dest);
				expData.push_back(result);
				// A load shows its address in the memory stage
				expAlu.push_back(w.i.opcode == opLw ? addr : result);
			end
			steps++;
		end
		expCount = expReg.size();
	endtask

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Edges since reset release
	always @(posedge clk) begin
		if (reset)
			edgeCount = 0;
		else
			edgeCount = edgeCount + 1;
	end

	// Writeback monitor, sampled mid cycle
	// ALU output of the previous cycle belongs to the same instruction
	always @(negedge clk) begin
		if (!reset && wbEnable) begin
			if (wbSeen == 0)
				checkValue("first writeback cycle", 32'd4, 32'(edgeCount));
			if (wbSeen < expCount) begin
				checkValue($sformatf("writeback %0d register", wbSeen),
					32'(expReg[wbSeen]), 32'(wbRegister));
				checkValue($sformatf("writeback %0d data", wbSeen),
					expData[wbSeen], wbData);
				checkValue($sformatf("writeback %0d ALU result", wbSeen),
					expAlu[wbSeen], prevAlu);
			end else begin
				errors++;
				$display("Unexpected writeback to register %0d after all %0d expected ones",
					wbRegister, expCount);
			end
			wbSeen++;
		end
		prevAlu = aluResultOut;
	end

	initial begin
		#(timeoutNs);
		$display("Watchdog expired with %0d of %0d writebacks seen", wbSeen, expCount);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		lfsrState = 16'd41;
		redirects = 0;
		buildProgram();
		runModel();
		$display("Program %0d words, %0d writebacks, %0d redirects expected",
			progLen, expCount, redirects);
		// Instruction memory load while reset holds the core
		for (int a = 0; a < `IMEM_DEPTH; a++) begin
			@(posedge clk);
			#1;
			progWrite = 1'b1;
			progAddr = a[`IMEM_ADDR_WIDTH-1:0];
			progData = progMem[a];
		end
		@(posedge clk);
		#1;
		progWrite = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		wait (wbSeen >= expCount);
		// Drain so a late stray writeback still shows
		repeat (6) @(posedge clk);
		$display("Checks %0d, errors %0d, writebacks seen %0d of %0d",
			checks, errors, wbSeen, expCount);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
